// ==== project.f ====
+incdir+src
src/uart_pkg.sv
src/baud_gen.sv
src/tx_ctrl_fsm.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/uart_wrapper.sv
bench/uart_tb.sv

// ==== bench/uart_tb.sv ====
`include "uart_config.svh"
`default_nettype none
`timescale 1ns/1ps

module uart_tb
    import uart_pkg::*;
();

    localparam int TIMEOUT = 200000;    // Cycles; longer than any frame at 9600 baud.

    logic          clk_50;
    logic          reset;
    logic          cs;
    logic          rwb;
    logic          addr;
    logic [7:0]    write_data;
    logic [7:0]    read_data;
    logic          rx_serial;
    logic          tx_serial;
    logic          irqb;
    integer        seed;
    int            cycle_count = 0;
    int            errors = 0;
    string         test_name;
    uart_control_t exp_control;
    uart_status_t  exp_status;
    logic [7:0]    exp_rx_byte;

    uart_wrapper u_uart_wrapper (
        .clk_50     (clk_50),
        .reset      (reset),
        .cs         (cs),
        .rwb        (rwb),
        .addr       (addr),
        .write_data (write_data),
        .read_data  (read_data),
        .rx_serial  (rx_serial),
        .tx_serial  (tx_serial),
        .irqb       (irqb)
    );

    initial begin
        clk_50 = 1'b0;
        forever #2 clk_50 = ~clk_50;
    end

    always @(posedge clk_50) cycle_count <= cycle_count + 1;

    // ######################################################################
    // Checks
    // ######################################################################

    task automatic stop_with_error(string what);
        errors++;
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_byte(string what, logic [7:0] expected, logic [7:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAIL %s: %s expected 0x%02h actual 0x%02h",
                                      test_name, what, expected, actual));
        end
    endtask

    task automatic check_status(string what, uart_status_t expected, uart_status_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAIL %s: %s expected 0x%02h actual 0x%02h",
                                      test_name, what, expected, actual));
        end
    endtask

    task automatic check_irq(string what, logic expected, logic actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAIL %s: %s expected %b actual %b",
                                      test_name, what, expected, actual));
        end
    endtask

    task automatic check_line(string what, logic expected, logic actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAIL %s: %s expected %b actual %b",
                                      test_name, what, expected, actual));
        end
    endtask

    task automatic check_length(string what, int expected, int actual, int tolerance);
        if (actual > expected + tolerance || actual < expected - tolerance) begin
            stop_with_error($sformatf("FAIL %s: %s expected %0d actual %0d",
                                      test_name, what, expected, actual));
        end
    endtask

    // ######################################################################
    // Bus and serial line
    // ######################################################################

    function automatic int divisor_for(logic [1:0] sel);
        case (sel)
            2'd0: return `UART_DIV_0;
            2'd1: return `UART_DIV_1;
            2'd2: return `UART_DIV_2;
            default: return `UART_DIV_3;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk_50);
        #1;    // Inputs change just after the edge.
    endtask

    task automatic bus_write(logic a, logic [7:0] data);
        cs         = 1'b1;
        rwb        = 1'b0;
        addr       = a;
        write_data = data;
        next_cycle();
        cs  = 1'b0;
        rwb = 1'b1;
    endtask

    task automatic bus_read(logic a, output logic [7:0] data);
        cs   = 1'b1;
        rwb  = 1'b1;
        addr = a;
        #1;
        data = read_data;    // Read data is combinational, so it has settled here.
        next_cycle();
        cs = 1'b0;
    endtask

    task automatic read_status(output uart_status_t st);
        logic [7:0] data;
        bus_read(1'b1, data);
        st = data;
    endtask

    task automatic wait_tx_idle();
        uart_status_t st;
        int           n;
        n = 0;
        read_status(st);
        while (st.tx_busy) begin
            n++;
            if (n > TIMEOUT) stop_with_error("timeout waiting for the transmitter to go idle");
            read_status(st);
        end
    endtask

    task automatic wait_rx_ready();
        uart_status_t st;
        int           n;
        n = 0;
        read_status(st);
        while (!st.rx_ready) begin
            n++;
            if (n > TIMEOUT) stop_with_error("timeout waiting for a received byte");
            read_status(st);
        end
    endtask

    task automatic drive_serial_frame(logic [7:0] data, logic stop_level, int div);
        logic [9:0] bits;
        bits = {stop_level, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_serial = bits[i];
            repeat (16 * div) next_cycle();
        end
        rx_serial = 1'b1;
        repeat (16 * div) next_cycle();    // One idle bit before the next frame.
    endtask

    // Samples tx_serial at bit centers and times the frame up to the end of busy.
    task automatic capture_tx_frame(int div, output logic [7:0] data);
        int n;
        int start_cycle;
        n = 0;
        while (tx_serial !== 1'b0) begin
            n++;
            if (n > TIMEOUT) stop_with_error("timeout waiting for a start bit on tx_serial");
            next_cycle();
        end
        start_cycle = cycle_count;
        repeat (8 * div) next_cycle();
        check_line("start bit", 1'b0, tx_serial);
        for (int i = 0; i < 8; i++) begin
            repeat (16 * div) next_cycle();
            data[i] = tx_serial;
        end
        repeat (16 * div) next_cycle();
        check_line("stop bit", 1'b1, tx_serial);
        wait_tx_idle();
        check_length("frame clocks", 160 * div, cycle_count - 1 - start_cycle, div);
    endtask

    task automatic transmit_byte(logic [7:0] data, int div);
        uart_status_t st;
        logic [7:0]   got;
        wait_tx_idle();
        bus_write(1'b0, data);
        exp_status.tx_busy = 1'b1;
        read_status(st);
        check_status("status after write", exp_status, st);
        capture_tx_frame(div, got);
        exp_status.tx_busy = 1'b0;
        check_byte("transmitted byte", data, got);
    endtask

    task automatic receive_byte(logic [7:0] data, logic stop_level, int div);
        uart_status_t st;
        logic [7:0]   got;
        drive_serial_frame(data, stop_level, div);
        wait_rx_ready();
        exp_rx_byte              = data;
        exp_status.rx_ready      = 1'b1;
        exp_status.framing_error = !stop_level;
        check_irq("irqb with byte ready", !exp_control.rx_irq_en, irqb);
        read_status(st);
        check_status("status with byte ready", exp_status, st);
        bus_read(1'b0, got);
        check_byte("received byte", exp_rx_byte, got);
        exp_status.rx_ready      = 1'b0;
        exp_status.framing_error = 1'b0;
        next_cycle();
        check_irq("irqb after data read", 1'b1, irqb);
        read_status(st);
        check_status("status after data read", exp_status, st);
    endtask

    // ######################################################################
    // Test sequence
    // ######################################################################

    initial begin
        uart_status_t st;
        logic [7:0]   data;
        int           div;
        seed        = 32'hce6c_6560;
        reset       = 1'b1;
        cs          = 1'b0;
        rwb         = 1'b1;
        addr        = 1'b0;
        write_data  = 8'h00;
        rx_serial   = 1'b1;
        exp_control = '0;
        exp_status  = '0;
        exp_rx_byte = 8'h00;
        repeat (4) next_cycle();
        reset = 1'b0;
        next_cycle();

        test_name = "reset";
        check_line("tx_serial idle", 1'b1, tx_serial);
        check_irq("irqb idle", 1'b1, irqb);
        read_status(st);
        check_status("status", exp_status, st);

        test_name = "transmit";
        div = divisor_for(exp_control.baud_sel);
        repeat (20) begin
            data = $random(seed);
            transmit_byte(data, div);
        end

        test_name = "receive";
        repeat (20) begin
            data = $random(seed);
            receive_byte(data, 1'b1, div);
        end

        test_name = "framing error";
        data = $random(seed);
        receive_byte(data, 1'b0, div);

        test_name = "baud select";
        for (int sel = 0; sel < 4; sel++) begin
            exp_control           = '0;
            exp_control.rx_irq_en = 1'b1;
            exp_control.baud_sel  = 2'(sel);
            bus_write(1'b1, exp_control);
            div  = divisor_for(exp_control.baud_sel);
            data = $random(seed);
            transmit_byte(data, div);
            data = $random(seed);
            receive_byte(data, 1'b1, div);
        end

        test_name   = "interrupt disabled";
        exp_control = '0;    // Back to 115200 with the interrupt off.
        bus_write(1'b1, exp_control);
        div  = divisor_for(exp_control.baud_sel);
        data = $random(seed);
        receive_byte(data, 1'b1, div);

        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/uart_wrapper.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_wrapper
    import uart_pkg::*;
(
    input  wire        clk_50,
    input  wire        reset,
    input  wire        cs,
    input  wire        rwb,
    input  wire        addr,
    input  wire  [7:0] write_data,
    output logic [7:0] read_data,
    input  wire        rx_serial,
    output logic       tx_serial,
    output logic       irqb
);

    logic            tx_write;
    logic [7:0]      tx_data;
    logic [1:0]      baud_sel;
    logic            tx_en;
    logic            tx_busy;
    logic            tx_busy_flag;
    logic            baud_tick;
    logic            rx_valid;
    uart_rx_result_t rx_result;

    uart_regs u_uart_regs (
        .clk_50       (clk_50),
        .reset        (reset),
        .cs           (cs),
        .rwb          (rwb),
        .addr         (addr),
        .write_data   (write_data),
        .read_data    (read_data),
        .tx_write     (tx_write),
        .tx_data      (tx_data),
        .baud_sel     (baud_sel),
        .tx_busy_flag (tx_busy_flag),
        .rx_valid     (rx_valid),
        .rx_result    (rx_result),
        .irqb         (irqb)
    );

    tx_ctrl_fsm u_tx_ctrl_fsm (
        .clk_50       (clk_50),
        .reset        (reset),
        .tx_write     (tx_write),
        .tx_busy      (tx_busy),
        .tx_en        (tx_en),
        .tx_busy_flag (tx_busy_flag)
    );

    // One tick source shared by both directions.
    baud_gen u_baud_gen (
        .clk_50    (clk_50),
        .reset     (reset),
        .baud_sel  (baud_sel),
        .baud_tick (baud_tick)
    );

    uart_tx u_uart_tx (
        .clk_50    (clk_50),
        .reset     (reset),
        .baud_tick (baud_tick),
        .tx_en     (tx_en),
        .tx_data   (tx_data),
        .tx_busy   (tx_busy),
        .tx_serial (tx_serial)
    );

    uart_rx u_uart_rx (
        .clk_50    (clk_50),
        .reset     (reset),
        .baud_tick (baud_tick),
        .rx_serial (rx_serial),
        .rx_valid  (rx_valid),
        .rx_result (rx_result)
    );

endmodule

`default_nettype wire

// ==== src/uart_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_regs
    import uart_pkg::*;
(
    input  wire             clk_50,
    input  wire             reset,
    input  wire             cs,
    input  wire             rwb,
    input  wire             addr,
    input  wire [7:0]       write_data,
    output logic [7:0]      read_data,
    output logic            tx_write,
    output logic [7:0]      tx_data,
    output logic [1:0]      baud_sel,
    input  wire             tx_busy_flag,
    input  wire             rx_valid,
    input  wire uart_rx_result_t rx_result,
    output logic            irqb
);

    uart_control_t control;
    uart_reg1_t    reg1_wr;
    uart_reg1_t    reg1_rd;
    logic          rx_ready;
    logic          framing_error;
    logic [7:0]    rx_data;
    logic          wr_access;
    logic          rd_data0;

    assign wr_access = cs && !rwb;
    assign rd_data0  = cs && rwb && !addr;
    assign reg1_wr   = write_data;
    assign baud_sel  = control.baud_sel;

    always_ff @(posedge clk_50) begin
        if (reset) begin
            tx_write      <= 1'b0;
            control       <= '0;
            rx_ready      <= 1'b0;
            framing_error <= 1'b0;
            irqb          <= 1'b1;
        end else begin
            tx_write <= wr_access && !addr;    // Lines up with the new tx_data.
            if (wr_access && addr) begin
                control <= reg1_wr.control;
            end
            if (rx_valid) begin
                rx_ready      <= 1'b1;
                framing_error <= rx_result.framing_error | (framing_error & !rd_data0);
            end else if (rd_data0) begin
                rx_ready      <= 1'b0;
                framing_error <= 1'b0;
            end
            irqb <= !(rx_ready && control.rx_irq_en);
        end
    end

    always_ff @(posedge clk_50) begin
        if (wr_access && !addr) begin
            tx_data <= write_data;
        end
        if (rx_valid) begin
            rx_data <= rx_result.data;
        end
    end

    always_comb begin
        reg1_rd.status = '{
            reserved:      5'd0,
            framing_error: framing_error,
            tx_busy:       tx_busy_flag,
            rx_ready:      rx_ready
        };
        read_data = addr ? reg1_rd : rx_data;
    end

    // Reading the byte lets the interrupt go two cycles later.
    a_irq_released_by_read: assert property (
        @(posedge clk_50) disable iff (reset)
        rd_data0 && !rx_valid |-> ##2 irqb
    ) else $error("irqb still low two cycles after the received byte was read");

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
`include "uart_config.svh"
`default_nettype none
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
(
    input  wire             clk_50,
    input  wire             reset,
    input  wire             baud_tick,
    input  wire             rx_serial,
    output logic            rx_valid,
    output uart_rx_result_t rx_result
);

    localparam logic [3:0] MID_TICK  = 4'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [3:0] LAST_TICK = 4'(`UART_OVERSAMPLE - 1);
    localparam logic [3:0] STOP_BIT  = 4'd8;

    logic       rx_meta;
    logic       rx_sync;
    logic       rx_active;
    logic       in_start;
    logic [3:0] tick_cnt;
    logic [3:0] bit_cnt;
    logic [7:0] shifter;
    logic       at_mid;
    logic       at_sample;

    // ####################################################################
    // Input synchronizer
    // ####################################################################

    always_ff @(posedge clk_50) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_serial;
            rx_sync <= rx_meta;
        end
    end

    // ####################################################################
    // Bit timing and sampling
    // ####################################################################

    assign at_mid    = baud_tick && rx_active && in_start && (tick_cnt == MID_TICK);
    assign at_sample = baud_tick && rx_active && !in_start && (tick_cnt == LAST_TICK);

    always_ff @(posedge clk_50) begin
        if (reset) begin
            rx_active <= 1'b0;
            in_start  <= 1'b0;
            tick_cnt  <= 4'd0;
            bit_cnt   <= 4'd0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!rx_active) begin
                if (baud_tick && !rx_sync) begin
                    rx_active <= 1'b1;    // Start candidate.
                    in_start  <= 1'b1;
                    tick_cnt  <= 4'd0;
                end
            end else if (at_mid) begin
                // Middle of the start bit; a high line here was a glitch.
                rx_active <= !rx_sync;
                in_start  <= 1'b0;
                tick_cnt  <= 4'd0;
                bit_cnt   <= 4'd0;
            end else if (at_sample) begin
                tick_cnt <= 4'd0;
                bit_cnt  <= bit_cnt + 1'b1;
                if (bit_cnt == STOP_BIT) begin
                    rx_active <= 1'b0;
                    rx_valid  <= 1'b1;
                end
            end else if (baud_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_50) begin
        if (at_sample && bit_cnt != STOP_BIT) begin
            shifter <= {rx_sync, shifter[7:1]};    // LSB arrives first.
        end
        if (at_sample && bit_cnt == STOP_BIT) begin
            rx_result.data          <= shifter;
            rx_result.framing_error <= !rx_sync;
        end
    end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`include "uart_config.svh"
`default_nettype none
`timescale 1ns/1ps

module uart_tx (
    input  wire       clk_50,
    input  wire       reset,
    input  wire       baud_tick,
    input  wire       tx_en,
    input  wire [7:0] tx_data,
    output logic      tx_busy,
    output logic      tx_serial
);

    localparam logic [3:0] LAST_TICK = 4'(`UART_OVERSAMPLE - 1);
    localparam logic [3:0] STOP_BIT  = 4'd9;

    logic [9:0] frame;        // Stop, data LSB first, start.
    logic       wait_tick;
    logic [3:0] tick_cnt;
    logic [3:0] bit_cnt;
    logic       accept;
    logic       bit_end;

    assign accept  = tx_en && !tx_busy;
    assign bit_end = baud_tick && tx_busy && !wait_tick && (tick_cnt == LAST_TICK);

    always_ff @(posedge clk_50) begin
        if (accept) begin
            frame <= {1'b1, tx_data, 1'b0};
        end else if (bit_end) begin
            frame <= frame >> 1;
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            tx_busy   <= 1'b0;
            wait_tick <= 1'b0;
            tick_cnt  <= 4'd0;
            bit_cnt   <= 4'd0;
            tx_serial <= 1'b1;
        end else if (accept) begin
            tx_busy   <= 1'b1;
            wait_tick <= 1'b1;    // Line stays idle until the next tick.
        end else if (tx_busy && baud_tick) begin
            if (wait_tick) begin
                wait_tick <= 1'b0;
                tick_cnt  <= 4'd0;
                bit_cnt   <= 4'd0;
                tx_serial <= frame[0];
            end else if (bit_end) begin
                tick_cnt <= 4'd0;
                if (bit_cnt == STOP_BIT) begin
                    tx_busy   <= 1'b0;
                    tx_serial <= 1'b1;
                end else begin
                    bit_cnt   <= bit_cnt + 1'b1;
                    tx_serial <= frame[1];
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk_50) disable iff (reset) !tx_busy |-> tx_serial
    ) else $error("tx_serial low while the transmitter is idle");

endmodule

`default_nettype wire

// ==== src/tx_ctrl_fsm.sv ====
`default_nettype none
`timescale 1ns/1ps

module tx_ctrl_fsm
    import uart_pkg::*;
(
    input  wire  clk_50,
    input  wire  reset,
    input  wire  tx_write,
    input  wire  tx_busy,
    output logic tx_en,
    output logic tx_busy_flag
);

    tx_ctrl_state_t state;
    tx_ctrl_state_t next_state;

    always_ff @(posedge clk_50) begin
        if (reset) begin
            state <= ready;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        tx_en      = 1'b0;
        case (state)
            ready: begin
                if (tx_write) begin
                    tx_en      = 1'b1;
                    next_state = wait_start;
                end
            end
            wait_start: begin
                tx_en = 1'b1;    // Held until the shifter takes the byte.
                if (tx_busy) begin
                    next_state = transmit;
                end
            end
            transmit: begin
                if (!tx_busy) begin
                    next_state = ready;
                end
            end
            default: next_state = ready;
        endcase
    end

    // Software sees busy from the cycle after the write.
    assign tx_busy_flag = tx_busy | tx_en;

    // A second request during a frame would start a frame the bus never wrote.
    a_no_en_in_transmit: assert property (
        @(posedge clk_50) disable iff (reset) $past(tx_busy) |-> !tx_en
    ) else $error("tx_en high in state %s", state.name());

endmodule

`default_nettype wire

// ==== src/baud_gen.sv ====
`include "uart_config.svh"
`default_nettype none
`timescale 1ns/1ps

module baud_gen (
    input  wire       clk_50,
    input  wire       reset,
    input  wire [1:0] baud_sel,
    output logic      baud_tick
);

    localparam logic [`UART_DIV_W-1:0] DIVISORS [4] = '{
        `UART_DIV_0, `UART_DIV_1, `UART_DIV_2, `UART_DIV_3
    };

    logic [`UART_DIV_W-1:0] divisor;
    logic [`UART_DIV_W-1:0] count;
    logic [1:0]             baud_sel_q;

    assign divisor = DIVISORS[baud_sel];

    always_ff @(posedge clk_50) begin
        if (reset) begin
            count      <= DIVISORS[0] - 1'b1;
            baud_sel_q <= 2'd0;
            baud_tick  <= 1'b0;
        end else begin
            baud_sel_q <= baud_sel;
            baud_tick  <= 1'b0;
            if (baud_sel != baud_sel_q) begin
                count <= divisor - 1'b1;    // New rate starts a full period.
            end else if (count == '0) begin
                count     <= divisor - 1'b1;
                baud_tick <= 1'b1;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // ####################################################################
    // Register word at address 1
    // ####################################################################

    typedef struct packed {
        logic [4:0] reserved;
        logic       framing_error;
        logic       tx_busy;
        logic       rx_ready;
    } uart_status_t;

    typedef struct packed {
        logic [4:0] reserved;
        logic       rx_irq_en;
        logic [1:0] baud_sel;
    } uart_control_t;

    // Status when read, control when written.
    typedef union packed {
        uart_status_t  status;
        uart_control_t control;
    } uart_reg1_t;

    typedef enum logic [1:0] {
        ready,
        wait_start,
        transmit
    } tx_ctrl_state_t;

    typedef struct packed {
        logic [7:0] data;
        logic       framing_error;
    } uart_rx_result_t;

endpackage

`default_nettype wire

// ==== src/uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

`default_nettype none

`define UART_CLK_HZ     50000000
`define UART_OVERSAMPLE 16

// Clocks per 16x tick for 115200, 57600, 19200 and 9600 baud.
`define UART_DIV_0      27
`define UART_DIV_1      54
`define UART_DIV_2      163
`define UART_DIV_3      326
`define UART_DIV_W      9

`default_nettype wire

`endif
